//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // bus timing, CLK cycles per SCL half period
    localparam int SCL_HALF = 4;

    localparam logic [3:0] DEV_TYPE = 4'b1010;  // 24Cxx device type code

    localparam int ADDR_W = 11;
    localparam int FIFO_DEPTH = 4;

    typedef struct packed {
        logic              write;  // 1 = byte write, 0 = random read
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } cmd_t;

    typedef struct packed {
        logic [7:0] rdata;  // zero for writes
        logic       nack;
    } rsp_t;

endpackage

`default_nettype wire

//--- src/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import eeprom_pkg::*;
#(
    parameter type T = logic [7:0],
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic in_valid,
    output logic      in_ready,
    input  wire T     in_data,
    output logic      out_valid,
    input  wire logic out_ready,
    output T          out_data
);
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    T mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic push;
    logic pop;

    assign in_ready  = (count != FULL);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/scl_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scl_timer
    import eeprom_pkg::*;
(
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic run,
    output logic      scl,
    output logic      low_mid,
    output logic      high_mid
);
    localparam int CNT_W = (SCL_HALF > 1) ? $clog2(SCL_HALF) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(SCL_HALF / 2);

    logic [CNT_W-1:0] cnt;
    logic scl_q;
    logic active;

    // keep going until the low half is done, then park high
    assign active = run || !scl_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cnt   <= '0;
            scl_q <= 1'b1;
        end
        else if (active) begin
            if (cnt == LAST) begin
                cnt   <= '0;
                scl_q <= ~scl_q;
            end
            else
                cnt <= cnt + 1'b1;
        end
        else
            cnt <= '0;
    end

    assign scl      = scl_q;
    assign low_mid  = run && !scl_q && (cnt == MID);
    assign high_mid = run && scl_q && (cnt == MID);

endmodule

`default_nettype wire

//--- src/eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic cmd_valid,
    output logic      cmd_ready,
    input  wire cmd_t cmd,
    output logic      rsp_valid,
    input  wire logic rsp_ready,
    output rsp_t      rsp,
    output logic      run,
    input  wire logic scl,
    input  wire logic low_mid,
    input  wire logic high_mid,
    output logic      sda_oe,
    input  wire logic sda_in
);
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_RCTRL,
        S_READ,
        S_MNACK,
        S_STOP,
        S_RESP
    } state_t;

    state_t state;
    cmd_t cur;              // command being served
    logic [7:0] sh;         // shared tx/rx shift register
    logic [3:0] bit_cnt;    // 0..7 data, 8 = ack slot
    logic [7:0] rdata;
    logic nack;
    logic run_q;
    logic sda_oe_q;
    logic take;

    // only start when the response has a place to go and the clock is parked
    assign cmd_ready = (state == S_IDLE) && rsp_ready && scl;
    assign take      = cmd_valid && cmd_ready;
    assign rsp_valid = (state == S_RESP);
    assign rsp       = '{rdata: rdata, nack: nack};
    assign run       = run_q;
    assign sda_oe    = sda_oe_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            nack     <= 1'b0;
            run_q    <= 1'b0;
            sda_oe_q <= 1'b0;
        end
        else begin
            case (state)
                S_IDLE:
                    if (take) begin
                        cur   <= cmd;
                        nack  <= 1'b0;
                        rdata <= 8'h00;
                        run_q <= 1'b1;
                        state <= S_START;
                    end
                S_START:
                    if (high_mid) begin
                        sda_oe_q <= 1'b1;  // start, SDA falls with SCL high
                        sh       <= {DEV_TYPE, cur.addr[ADDR_W-1 -: 3], 1'b0};
                        bit_cnt  <= '0;
                        state    <= S_CTRL;
                    end
                S_CTRL, S_ADDR, S_DATA, S_RCTRL:
                    if (low_mid) begin
                        if (bit_cnt == 4'd8)
                            sda_oe_q <= 1'b0;  // let the slave ack
                        else begin
                            sda_oe_q <= ~sh[7];  // msb first
                            sh       <= {sh[6:0], 1'b0};
                        end
                    end
                    else if (high_mid) begin
                        if (bit_cnt != 4'd8)
                            bit_cnt <= bit_cnt + 4'd1;
                        else begin
                            bit_cnt <= '0;
                            if (sda_in) begin
                                // no ack from the slave, abort
                                nack  <= 1'b1;
                                state <= S_STOP;
                            end
                            else begin
                                case (state)
                                    S_CTRL: begin
                                        sh    <= cur.addr[7:0];
                                        state <= S_ADDR;
                                    end
                                    S_ADDR:
                                        if (cur.write) begin
                                            sh    <= cur.wdata;
                                            state <= S_DATA;
                                        end
                                        else
                                            state <= S_RSTART;
                                    S_DATA:
                                        state <= S_STOP;
                                    default:
                                        state <= S_READ;  // read control acked
                                endcase
                            end
                        end
                    end
                S_RSTART:
                    if (low_mid)
                        sda_oe_q <= 1'b0;  // SDA high before SCL rises
                    else if (high_mid) begin
                        sda_oe_q <= 1'b1;  // repeated start
                        sh       <= {DEV_TYPE, cur.addr[ADDR_W-1 -: 3], 1'b1};
                        state    <= S_RCTRL;
                    end
                S_READ:
                    if (low_mid)
                        sda_oe_q <= 1'b0;
                    else if (high_mid) begin
                        sh <= {sh[6:0], sda_in};
                        if (bit_cnt == 4'd7) begin
                            rdata   <= {sh[6:0], sda_in};
                            bit_cnt <= '0;
                            state   <= S_MNACK;
                        end
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                S_MNACK:
                    if (low_mid)
                        sda_oe_q <= 1'b0;  // leave SDA high, single byte read
                    else if (high_mid)
                        state <= S_STOP;
                S_STOP:
                    if (low_mid)
                        sda_oe_q <= 1'b1;
                    else if (high_mid) begin
                        sda_oe_q <= 1'b0;  // stop, SDA rises with SCL high
                        run_q    <= 1'b0;
                        state    <= S_RESP;
                    end
                S_RESP:
                    if (rsp_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/eeprom_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_top
    import eeprom_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              cmd_valid,
    output logic                   cmd_ready,
    input  wire logic              cmd_write,
    input  wire logic [ADDR_W-1:0] cmd_addr,
    input  wire logic [7:0]        cmd_wdata,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output logic [7:0]             rsp_rdata,
    output logic                   rsp_nack,
    output logic                   scl,
    output logic                   sda_oe,
    input  wire logic              sda_in
);
    cmd_t host_cmd;
    cmd_t q_cmd;
    logic q_cmd_valid;
    logic q_cmd_ready;
    rsp_t c_rsp;
    logic c_rsp_valid;
    logic c_rsp_ready;
    rsp_t host_rsp;
    logic run;
    logic low_mid;
    logic high_mid;

    assign host_cmd  = '{write: cmd_write, addr: cmd_addr, wdata: cmd_wdata};
    assign rsp_rdata = host_rsp.rdata;
    assign rsp_nack  = host_rsp.nack;

    byte_fifo #(.T(cmd_t), .DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_data   (host_cmd),
        .out_valid (q_cmd_valid),
        .out_ready (q_cmd_ready),
        .out_data  (q_cmd)
    );

    byte_fifo #(.T(rsp_t), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (c_rsp_valid),
        .in_ready  (c_rsp_ready),
        .in_data   (c_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (host_rsp)
    );

    scl_timer u_scl_timer (
        .CLK      (CLK),
        .RESET    (RESET),
        .run      (run),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (q_cmd_valid),
        .cmd_ready (q_cmd_ready),
        .cmd       (q_cmd),
        .rsp_valid (c_rsp_valid),
        .rsp_ready (c_rsp_ready),
        .rsp       (c_rsp),
        .run       (run),
        .scl       (scl),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

//--- verif/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
    import eeprom_pkg::*;
(
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic enable,
    output logic      sda_oe
);
    typedef enum logic [1:0] {
        P_CTRL,
        P_ADDR,
        P_DATA,
        P_DONE
    } phase_t;

    logic [7:0] mem [2**ADDR_W];
    logic loaded = 1'b0;
    logic prev_scl = 1'b1;
    logic prev_sda = 1'b1;
    logic oe = 1'b0;
    logic active = 1'b0;
    logic tx_byte = 1'b0;     // byte on the bus comes from the model
    logic pending_tx = 1'b0;
    logic [3:0] bit_cnt = 4'd0;
    logic [7:0] sh = 8'h00;
    logic [7:0] tx = 8'h00;
    logic [2:0] blk = 3'd0;
    logic [7:0] addr_lo = 8'h00;
    phase_t phase = P_CTRL;
    logic ack;

    assign sda_oe = oe;

    // one block sees both lines, start and stop are told apart from clock edges
    always @(scl or sda) begin
        if (!loaded) begin
            for (int i = 0; i < 2**ADDR_W; i++)
                mem[i[ADDR_W-1:0]] = 8'hFF;
            loaded = 1'b1;
        end
        if (scl === prev_scl) begin
            if (scl === 1'b1 && sda === 1'b0 && prev_sda === 1'b1) begin
                active     = 1'b1;  // start or repeated start
                bit_cnt    = 4'd0;
                phase      = P_CTRL;
                tx_byte    = 1'b0;
                pending_tx = 1'b0;
                oe         = 1'b0;
            end
            else if (scl === 1'b1 && sda === 1'b1 && prev_sda === 1'b0) begin
                active = 1'b0;  // stop
                oe     = 1'b0;
            end
        end
        else if (scl === 1'b1 && active) begin
            if (bit_cnt < 4'd8) begin
                if (!tx_byte)
                    sh = {sh[6:0], sda === 1'b0 ? 1'b0 : 1'b1};
                bit_cnt = bit_cnt + 4'd1;
            end
            else begin
                // ninth clock
                bit_cnt = 4'd0;
                if (tx_byte) begin
                    tx_byte = 1'b0;
                    phase   = P_DONE;
                end
                else if (pending_tx) begin
                    tx_byte    = 1'b1;
                    pending_tx = 1'b0;
                end
            end
        end
        else if (scl === 1'b0 && active) begin
            if (bit_cnt == 4'd8 && !tx_byte) begin
                ack = enable;
                if (enable) begin
                    case (phase)
                        P_CTRL:
                            if (sh[7:4] != DEV_TYPE)
                                ack = 1'b0;
                            else begin
                                blk = sh[3:1];
                                if (sh[0]) begin
                                    tx         = mem[{blk, addr_lo}];
                                    pending_tx = 1'b1;
                                    phase      = P_DONE;
                                end
                                else
                                    phase = P_ADDR;
                            end
                        P_ADDR: begin
                            addr_lo = sh;
                            phase   = P_DATA;
                        end
                        P_DATA: begin
                            mem[{blk, addr_lo}] = sh;
                            phase = P_DONE;
                        end
                        default:
                            ack = 1'b0;
                    endcase
                end
                oe = ack;
            end
            else if (tx_byte && bit_cnt < 4'd8) begin
                oe = ~tx[7];  // msb first
                tx = {tx[6:0], 1'b0};
            end
            else
                oe = 1'b0;
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

`default_nettype wire

//--- verif/eeprom_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_asserts
    import eeprom_pkg::*;
(
    input wire logic              CLK,
    input wire logic              RESET,
    input wire logic              cmd_valid,
    input wire logic              cmd_ready,
    input wire logic              cmd_write,
    input wire logic [ADDR_W-1:0] cmd_addr,
    input wire logic [7:0]        cmd_wdata,
    input wire logic              rsp_valid,
    input wire logic              rsp_ready,
    input wire logic [7:0]        rsp_rdata,
    input wire logic              rsp_nack,
    input wire logic              scl,
    input wire logic              sda_in,
    input wire logic              run,
    input wire logic              high_mid
);
    // SDA may only move under a high SCL when the master makes a start or stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |-> $past(high_mid))
        else $error("SDA changed while SCL was high outside a start or stop");

    a_scl_idle: assert property (@(posedge CLK) disable iff (RESET)
        !run |-> scl)
        else $error("SCL low with no transaction in progress");

    a_cmd_hold: assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && !cmd_ready) |=>
            (cmd_valid && $stable({cmd_write, cmd_addr, cmd_wdata})))
        else $error("command dropped or changed before it was accepted");

    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable({rsp_rdata, rsp_nack})))
        else $error("response dropped or changed before it was taken");

endmodule

bind eeprom_top eeprom_asserts u_asserts (
    .CLK       (CLK),
    .RESET     (RESET),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .scl       (scl),
    .sda_in    (sda_in),
    .run       (run),
    .high_mid  (high_mid)
);

`default_nettype wire

//--- verif/tb_eeprom.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom
    import eeprom_pkg::*;
();
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
        logic              en;     // model answers
        logic              burst;  // back-to-back with response stalls
    } row_t;

    localparam int N_ROWS = 22;
    localparam int WAIT_LIMIT = 16 * (40 * 2 * SCL_HALF + 512);

    row_t rows [N_ROWS] = '{
        '{1'b0, 11'h123, 8'h00, 1'b1, 1'b0},  // unwritten address reads FF
        '{1'b1, 11'h123, 8'hA5, 1'b1, 1'b0},
        '{1'b0, 11'h123, 8'h00, 1'b1, 1'b0},
        '{1'b1, 11'h023, 8'h3C, 1'b1, 1'b0},  // same low byte in another block
        '{1'b0, 11'h123, 8'h00, 1'b1, 1'b0},
        '{1'b0, 11'h023, 8'h00, 1'b1, 1'b0},
        '{1'b1, 11'h7FF, 8'h5A, 1'b1, 1'b0},
        '{1'b1, 11'h123, 8'h11, 1'b0, 1'b0},
        '{1'b0, 11'h123, 8'h00, 1'b0, 1'b0},
        '{1'b0, 11'h123, 8'h00, 1'b1, 1'b0},
        '{1'b0, 11'h7FF, 8'h00, 1'b1, 1'b0},
        '{1'b1, 11'h400, 8'h01, 1'b1, 1'b1},
        '{1'b1, 11'h500, 8'h02, 1'b1, 1'b1},
        '{1'b0, 11'h400, 8'h00, 1'b1, 1'b1},
        '{1'b1, 11'h600, 8'h03, 1'b1, 1'b1},
        '{1'b0, 11'h500, 8'h00, 1'b1, 1'b1},
        '{1'b0, 11'h600, 8'h00, 1'b1, 1'b1},
        '{1'b1, 11'h400, 8'hC4, 1'b1, 1'b1},
        '{1'b0, 11'h400, 8'h00, 1'b1, 1'b1},
        '{1'b0, 11'h023, 8'h00, 1'b1, 1'b1},
        '{1'b0, 11'h0FE, 8'h00, 1'b1, 1'b1},
        '{1'b0, 11'h7FF, 8'h00, 1'b1, 1'b1}
    };

    logic CLK;
    logic RESET;
    logic cmd_valid;
    logic cmd_write;
    logic [ADDR_W-1:0] cmd_addr;
    logic [7:0] cmd_wdata;
    logic rsp_ready;
    logic model_en;
    logic stall_mode;
    wire logic cmd_ready;
    wire logic rsp_valid;
    wire logic [7:0] rsp_rdata;
    wire logic rsp_nack;
    wire logic scl;
    wire logic sda_oe;
    wire logic model_oe;
    wire logic sda;

    logic [7:0] shadow [2**ADDR_W];
    rsp_t exp_q [$];
    rsp_t got_rsp;
    int sent = 0;
    int received = 0;
    int stalled_sends = 0;
    int mismatches = 0;
    int failures = 0;
    logic timed_out = 1'b0;

    assign sda = !(sda_oe || model_oe);  // wired-AND with pull-up

    eeprom_top UUT (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_model u_model (
        .scl    (scl),
        .sda    (sda),
        .enable (model_en),
        .sda_oe (model_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic report_timeout(input string what);
        failures++;
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic check_rsp(input rsp_t got, input rsp_t exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: response rdata %h nack %b, expected rdata %h nack %b",
                     $time, got.rdata, got.nack, exp.rdata, exp.nack);
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: %0d responses for %0d commands", $time, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // entered and left on a falling edge
    task automatic send_cmd(input row_t r);
        int n;
        rsp_t e;
        cmd_valid = 1'b1;
        cmd_write = r.write;
        cmd_addr  = r.addr;
        cmd_wdata = r.wdata;
        n = 0;
        while (!timed_out && !cmd_ready)
        begin
            if (n == WAIT_LIMIT)
                report_timeout("command port never became ready");
            else
            begin
                n++;
                @(negedge CLK);
            end
        end
        if (n != 0)
            stalled_sends++;
        if (!timed_out)
        begin
            @(posedge CLK);
            e.nack  = !r.en;
            e.rdata = (r.write || !r.en) ? 8'h00 : shadow[r.addr];
            if (r.write && r.en)
                shadow[r.addr] = r.wdata;
            exp_q.push_back(e);
            sent++;
            @(negedge CLK);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (!timed_out && received < sent)
        begin
            if (n == WAIT_LIMIT)
                report_timeout("responses stopped before every command was answered");
            else
            begin
                n++;
                @(negedge CLK);
            end
        end
    endtask

    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid && rsp_ready)
        begin
            got_rsp = '{rdata: rsp_rdata, nack: rsp_nack};
            if (exp_q.size() == 0)
            begin
                failures++;
                $display("response arrived with no command outstanding");
            end
            else
                check_rsp(got_rsp, exp_q.pop_front());
            received++;
        end
    end

    // random response stalls in burst rows
    initial
    begin
        int stall_left;
        void'($urandom(32'ha80ea593));
        stall_left = 0;
        rsp_ready = 1'b1;
        forever
        begin
            @(negedge CLK);
            if (!stall_mode)
            begin
                rsp_ready  = 1'b1;
                stall_left = 0;
            end
            else if (stall_left != 0)
            begin
                rsp_ready = 1'b0;
                stall_left--;
            end
            else
            begin
                rsp_ready  = 1'b1;
                stall_left = $urandom % 500;
            end
        end
    end

    initial
    begin
        row_t r;
        RESET      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = 8'h00;
        model_en   = 1'b1;
        stall_mode = 1'b0;
        for (int i = 0; i < 2**ADDR_W; i++)
            shadow[i[ADDR_W-1:0]] = 8'hFF;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
        check_bit(sda_oe, 1'b0, "sda_oe after reset");
        check_bit(scl, 1'b1, "scl after reset");
        check_bit(cmd_ready, 1'b1, "cmd_ready after reset");

        for (int i = 0; i < N_ROWS && !timed_out; i++)
        begin
            r = rows[i];
            if (!r.burst)
            begin
                wait_drain();
                stall_mode = 1'b0;
                model_en   = r.en;
            end
            else
                stall_mode = 1'b1;
            send_cmd(r);
            if (!r.burst)
                wait_drain();
        end
        wait_drain();
        stall_mode = 1'b0;
        if (!timed_out)
        begin
            repeat (48 * 2 * SCL_HALF) @(negedge CLK);  // room for a stray response
            check_count(received, sent);
            check_bit(stalled_sends != 0, 1'b1, "cmd_ready low in the burst");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/eeprom_pkg.sv
src/byte_fifo.sv
src/scl_timer.sv
src/eeprom_ctrl.sv
src/eeprom_top.sv
verif/eeprom_model.sv
verif/eeprom_asserts.sv
verif/tb_eeprom.sv

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_eeprom -f tb.f -o sim_eeprom \
    && ./obj_dir/sim_eeprom > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
